//--- vlog.f
rtl/boot_pkg.sv
rtl/boot_cfg.sv
rtl/boot_ctrl.sv
rtl/uart_link.sv
rtl/inst_mem.sv
rtl/boot_top.sv
verif/tb_clk.sv
verif/boot_chk.sv
verif/boot_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= boot_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/boot_tb.sv
`timescale 1ns/100ps

module boot_tb;

    localparam int IMEM_WORDS = 256;
    localparam int PROG_WORDS = 16;
    localparam int WORD_GAP   = 3;
    localparam int INIT_WAIT  = 10;
    localparam int RUN_GAP    = 17;
    localparam logic [7:0] PROBE = 8'h3c;
    // about 7 cycles per loaded word plus one short init wait and wide margin
    localparam int TIMEOUT_CYC = 20000;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } prog_entry_t;

    logic                        clk;
    logic                        native_rstn;
    logic                        rx_valid;
    logic [7:0]                  rx_byte;
    logic                        tx_valid;
    logic [7:0]                  tx_byte;
    logic                        usr_load;
    logic                        usr_rst;
    logic                        cfg_we;
    logic                        cfg_addr;
    logic [15:0]                 cfg_wdata;
    boot_pkg::link_req_t         core_req;
    boot_pkg::link_rsp_t         core_rsp;
    logic [boot_pkg::WORD_W-1:0] fetch_addr;
    logic [boot_pkg::WORD_W-1:0] fetch_data;
    logic                        fetch_valid;
    logic                        core_busy;
    logic                        context_init;
    logic [31:0]                 cycle_count;
    logic [3:0]                  led_stat;

    prog_entry_t prog [PROG_WORDS];
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          test_cnt = 0;
    int          test_err0 = 0;
    int          cyc_cnt = 0;
    int          gate_bad = 0;
    logic        gate_watch = 1'b0;

    tb_clk u_tb_clk (
        .clk         (clk),
        .native_rstn (native_rstn)
    );

    boot_top #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_boot_top (
        .clk          (clk),
        .native_rstn  (native_rstn),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .tx_valid     (tx_valid),
        .tx_byte      (tx_byte),
        .usr_load     (usr_load),
        .usr_rst      (usr_rst),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .core_req     (core_req),
        .core_rsp     (core_rsp),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid),
        .core_busy    (core_busy),
        .context_init (context_init),
        .cycle_count  (cycle_count),
        .led_stat     (led_stat)
    );

    bind boot_ctrl boot_chk u_boot_chk (
        .clk          (clk),
        .native_rstn  (native_rstn),
        .usr_rst      (usr_rst),
        .usr_load     (usr_load),
        .state        (state),
        .context_init (context_init),
        .core_rsp     (core_rsp),
        .prold        (prold)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check(input logic ok, input string msg);
        chk_cnt++;
        assert (ok) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
        end
        test_err0 = err_cnt;
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx_valid = 1'b1;
        rx_byte  = b;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    // host sends a word lsb first after a short idle gap
    task automatic send_word(input logic [31:0] w);
        repeat (WORD_GAP) @(negedge clk);
        for (int b = 0; b < 4; b++) begin
            send_byte(w[8*b +: 8]);
        end
    endtask

    task automatic cfg_write(input logic addr, input logic [15:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Some tests failed");
            $finish;
        end
    end

    // nothing may reach the core or the tx line while loading
    always @(negedge clk) begin
        if (gate_watch && (core_rsp.accepted || core_rsp.done || tx_valid)) begin
            gate_bad++;
        end
    end

    initial begin
        logic [31:0] lfsr;
        logic [31:0] word;
        logic [31:0] cnt_a;
        logic [7:0]  tx_first;
        logic [7:0]  tx_seen [$];
        logic        done_seen;
        logic        done_on_last;
        int          cyc;
        int          tx_cnt;
        int          tx_cyc;
        int          ctx_cnt;
        int          ctx_cyc;
        int          run_cnt;
        int          init_gap;

        rx_valid   = 1'b0;
        rx_byte    = 8'h00;
        usr_load   = 1'b0;
        usr_rst    = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_wdata  = 16'h0000;
        core_req   = '0;
        fetch_addr = '0;
        core_busy  = 1'b0;

        lfsr = 32'h5c1c_696c;
        for (int i = 0; i < PROG_WORDS; i++) begin
            word = '0;
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                word = {word[30:0], lfsr[0]};
            end
            prog[i].addr = 32'(i);
            prog[i].data = word;
        end

        @(posedge native_rstn);
        @(negedge clk);
        check(led_stat == 4'h0, $sformatf("led_stat %h after reset", led_stat));
        check(!tx_valid, "tx_valid high after reset");
        check(!context_init, "context_init high after reset");
        check(!fetch_valid, "fetch_valid high after reset");
        end_test("reset state");

        usr_load = 1'b1;
        @(negedge clk);
        usr_load = 1'b0;
        // core asks for a write the whole time the program streams in
        core_req.order = 1'b1;
        core_req.size  = boot_pkg::SZ_1;
        core_req.write = 1'b1;
        core_req.wdata = 32'h0000_0055;
        core_busy  = 1'b1;
        gate_watch = 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            send_word(prog[i].data);
        end
        repeat (4) @(negedge clk);
        gate_watch = 1'b0;
        check(led_stat == 4'b1001, $sformatf("led_stat %b during busy load", led_stat));
        core_req   = '0;
        core_busy  = 1'b0;
        check(gate_bad == 0, $sformatf("%0d core or tx events during load", gate_bad));
        end_test("load gating");

        cfg_write(1'b0, 16'(INIT_WAIT));
        cfg_write(1'b1, {8'h00, PROBE});
        usr_rst = 1'b1;
        @(negedge clk);
        usr_rst  = 1'b0;
        cyc      = 0;
        tx_cnt   = 0;
        tx_cyc   = 0;
        ctx_cnt  = 0;
        ctx_cyc  = 0;
        run_cnt  = 0;
        init_gap = 0;
        tx_first = 8'h00;
        while (run_cnt < 4) begin
            // pad bytes close the read the link opened after the last word
            rx_valid = (cyc < 4);
            if (tx_valid) begin
                tx_cnt++;
                if (tx_cnt == 1) begin
                    tx_first = tx_byte;
                    tx_cyc   = cyc;
                end
            end
            if (cyc >= 1 && tx_cnt == 0 && !led_stat[2]) begin
                init_gap++;
            end
            if (context_init) begin
                ctx_cnt++;
                ctx_cyc = cyc;
            end
            if (led_stat[1]) begin
                run_cnt++;
            end
            @(negedge clk);
            cyc++;
        end
        rx_valid = 1'b0;
        check(tx_cnt == 1, $sformatf("%0d probe bytes, expected 1", tx_cnt));
        check(tx_first == PROBE, $sformatf("probe byte %h, expected %h", tx_first, PROBE));
        check(tx_cyc >= INIT_WAIT + 2, $sformatf("probe after %0d cycles, too early", tx_cyc));
        check(ctx_cnt == 1, $sformatf("%0d context_init pulses, expected 1", ctx_cnt));
        check(ctx_cyc > tx_cyc, "context_init not after the probe byte");
        check(init_gap == 0, $sformatf("init led low for %0d cycles before probe", init_gap));
        end_test("init probe");

        for (int i = 0; i < PROG_WORDS; i++) begin
            fetch_addr = prog[i].addr;
            @(negedge clk);
            check(fetch_valid === 1'b1, $sformatf("fetch_valid low at addr %0d", i));
            check(fetch_data === prog[i].data,
                  $sformatf("fetch addr %0d: got %h, expected %h", i, fetch_data,
                            prog[i].data));
        end
        end_test("program fetch");

        core_req.order = 1'b1;
        core_req.size  = boot_pkg::SZ_2;
        core_req.write = 1'b1;
        core_req.wdata = 32'h0000_beef;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            if (core_rsp.accepted) begin
                core_req.order = 1'b0;
            end
            if (tx_valid) begin
                tx_seen.push_back(tx_byte);
            end
            done_seen = core_rsp.done;
        end
        done_on_last = tx_valid && (tx_seen.size() == 2);
        check(tx_seen.size() == 2, $sformatf("%0d tx bytes, expected 2", tx_seen.size()));
        check(tx_seen.size() > 0 && tx_seen[0] == 8'hef, "first tx byte is not ef");
        check(tx_seen.size() > 1 && tx_seen[1] == 8'hbe, "second tx byte is not be");
        check(done_on_last, "core_rsp.done not with the last tx byte");
        end_test("core write");

        word = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            word = {word[30:0], lfsr[0]};
        end
        core_req       = '0;
        core_req.order = 1'b1;
        core_req.size  = boot_pkg::SZ_4;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            done_seen = core_rsp.accepted;
        end
        core_req.order = 1'b0;
        for (int b = 0; b < 4; b++) begin
            send_byte(word[8*b +: 8]);
        end
        while (!core_rsp.done) begin
            @(negedge clk);
        end
        check(core_rsp.rdata == word,
              $sformatf("read data %h, expected %h", core_rsp.rdata, word));
        end_test("core read");

        cnt_a = cycle_count;
        repeat (RUN_GAP) @(negedge clk);
        check(cycle_count - cnt_a == 32'(RUN_GAP),
              $sformatf("cycle_count moved by %0d, expected %0d", cycle_count - cnt_a,
                        RUN_GAP));
        usr_load = 1'b1;
        @(negedge clk);
        usr_load = 1'b0;
        check(cycle_count == 32'd0, $sformatf("cycle_count %0d after load", cycle_count));
        repeat (5) @(negedge clk);
        check(cycle_count == 32'd0, "cycle_count moving outside run");
        end_test("run counter");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verif/boot_chk.sv
`timescale 1ns/100ps

module boot_chk (
    input logic                  clk,
    input logic                  native_rstn,
    input logic                  usr_rst,
    input logic                  usr_load,
    input boot_pkg::boot_state_e state,
    input logic                  context_init,
    input boot_pkg::link_rsp_t   core_rsp,
    input boot_pkg::prold_t      prold
);

    logic in_load;
    logic booted;

    assign in_load = (state == boot_pkg::ST_LD_WAIT) || (state == boot_pkg::ST_LD_WRITE);

    // set by the init strobe, dropped by a restart or a new load
    always_ff @(posedge clk) begin
        if (!native_rstn || usr_rst || usr_load) begin
            booted <= 1'b0;
        end else if (context_init) begin
            booted <= 1'b1;
        end
    end

    // init strobe is a single pulse
    ctx_one_cycle: assert property (@(posedge clk) disable iff (!native_rstn)
        context_init |=> !context_init)
        else $error("context_init high for more than one cycle");

    // core sees completions only once the init sequence has finished
    rsp_gated: assert property (@(posedge clk) disable iff (!native_rstn)
        core_rsp.done |-> (booted || context_init))
        else $error("core_rsp.done outside run");

    load_write_only: assert property (@(posedge clk) disable iff (!native_rstn)
        prold.order |-> in_load)
        else $error("prold.order outside a load state");

    // synchronous reset lands in ST_NONE
    rst_state: assert property (@(posedge clk)
        !native_rstn |=> (state == boot_pkg::ST_NONE))
        else $error("state not ST_NONE after reset");

endmodule

//--- verif/tb_clk.sv
`timescale 1ns/100ps

module tb_clk #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic native_rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        native_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        native_rstn = 1'b1;
    end

endmodule

//--- rtl/boot_top.sv
`timescale 1ns/100ps

module boot_top #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        native_rstn,
    input  logic                        rx_valid,
    input  logic [7:0]                  rx_byte,
    output logic                        tx_valid,
    output logic [7:0]                  tx_byte,
    input  logic                        usr_load,
    input  logic                        usr_rst,
    input  logic                        cfg_we,
    input  logic                        cfg_addr,
    input  logic [15:0]                 cfg_wdata,
    input  boot_pkg::link_req_t         core_req,
    output boot_pkg::link_rsp_t         core_rsp,
    input  logic [boot_pkg::WORD_W-1:0] fetch_addr,
    output logic [boot_pkg::WORD_W-1:0] fetch_data,
    output logic                        fetch_valid,
    input  logic                        core_busy,
    output logic                        context_init,
    output logic [31:0]                 cycle_count,
    output logic [3:0]                  led_stat
);

    logic [15:0]         init_wait;
    logic [7:0]          probe_byte;
    boot_pkg::link_req_t link_req;
    boot_pkg::link_rsp_t link_rsp;
    boot_pkg::prold_t    prold;
    logic                run;

    boot_cfg u_boot_cfg (
        .clk         (clk),
        .native_rstn (native_rstn),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .init_wait   (init_wait),
        .probe_byte  (probe_byte)
    );

    boot_ctrl u_boot_ctrl (
        .clk          (clk),
        .native_rstn  (native_rstn),
        .usr_rst      (usr_rst),
        .usr_load     (usr_load),
        .init_wait    (init_wait),
        .probe_byte   (probe_byte),
        .core_req     (core_req),
        .link_rsp     (link_rsp),
        .core_busy    (core_busy),
        .link_req     (link_req),
        .core_rsp     (core_rsp),
        .prold        (prold),
        .run          (run),
        .context_init (context_init),
        .cycle_count  (cycle_count),
        .led_stat     (led_stat)
    );

    uart_link u_uart_link (
        .clk         (clk),
        .native_rstn (native_rstn),
        .req         (link_req),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .rsp         (link_rsp),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte)
    );

    inst_mem #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_inst_mem (
        .clk         (clk),
        .native_rstn (native_rstn),
        .prold       (prold),
        .run         (run),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid)
    );

endmodule

//--- rtl/inst_mem.sv
`timescale 1ns/100ps

module inst_mem #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        native_rstn,
    input  boot_pkg::prold_t            prold,
    input  logic                        run,
    input  logic [boot_pkg::WORD_W-1:0] fetch_addr,
    output logic [boot_pkg::WORD_W-1:0] fetch_data,
    output logic                        fetch_valid
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [boot_pkg::WORD_W-1:0] mem [IMEM_WORDS];
    logic [AW-1:0]               wr_idx;
    logic [AW-1:0]               rd_idx;

    // load pc is a byte address, fetch_addr a word index
    assign wr_idx = prold.pc[AW+1:2];
    assign rd_idx = fetch_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (prold.mode && prold.order) begin
            mem[wr_idx] <= prold.data;
        end
    end

    always_ff @(posedge clk) begin
        fetch_data <= mem[rd_idx];
    end

    // valid only for addresses presented in run
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= run;
        end
    end

endmodule

//--- rtl/uart_link.sv
`timescale 1ns/100ps

module uart_link (
    input  logic                clk,
    input  logic                native_rstn,
    input  boot_pkg::link_req_t req,
    input  logic                rx_valid,
    input  logic [7:0]          rx_byte,
    output boot_pkg::link_rsp_t rsp,
    output logic                tx_valid,
    output logic [7:0]          tx_byte
);

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_READ,
        LK_WRITE
    } link_state_e;

    link_state_e                 state;
    logic [1:0]                  cnt;
    logic [1:0]                  last;
    logic                        accepted;
    logic                        done;
    logic [boot_pkg::WORD_W-1:0] shreg;

    // index of the final byte for a given size
    function automatic logic [1:0] last_index(input boot_pkg::xfer_size_e size);
        case (size)
            boot_pkg::SZ_1: last_index = 2'd0;
            boot_pkg::SZ_2: last_index = 2'd1;
            default:        last_index = 2'd3;
        endcase
    endfunction

    assign rsp = '{accepted: accepted, done: done, rdata: shreg};

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            state    <= LK_IDLE;
            cnt      <= '0;
            last     <= '0;
            accepted <= 1'b0;
            done     <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            accepted <= 1'b0;
            done     <= 1'b0;
            tx_valid <= 1'b0;
            case (state)
                LK_IDLE: begin
                    // orders only taken here, busy link ignores them
                    if (req.order) begin
                        accepted <= 1'b1;
                        cnt      <= '0;
                        last     <= last_index(req.size);
                        state    <= req.write ? LK_WRITE : LK_READ;
                    end
                end
                LK_READ: begin
                    if (rx_valid) begin
                        cnt <= cnt + 2'd1;
                        if (cnt == last) begin
                            done  <= 1'b1;
                            state <= LK_IDLE;
                        end
                    end
                end
                LK_WRITE: begin
                    // one byte per cycle, done with the last one
                    tx_valid <= 1'b1;
                    cnt      <= cnt + 2'd1;
                    if (cnt == last) begin
                        done  <= 1'b1;
                        state <= LK_IDLE;
                    end
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

    // shift register, lsb first in both directions
    always_ff @(posedge clk) begin
        case (state)
            LK_IDLE: begin
                if (req.order) begin
                    shreg <= req.write ? req.wdata : '0;
                end
            end
            LK_READ: begin
                if (rx_valid) begin
                    shreg[{cnt, 3'b000} +: 8] <= rx_byte;
                end
            end
            LK_WRITE: begin
                tx_byte <= shreg[7:0];
                shreg   <= shreg >> 8;
            end
            default: begin
                shreg <= shreg;
            end
        endcase
    end

endmodule

//--- rtl/boot_ctrl.sv
`timescale 1ns/100ps

module boot_ctrl (
    input  logic                clk,
    input  logic                native_rstn,
    input  logic                usr_rst,
    input  logic                usr_load,
    input  logic [15:0]         init_wait,
    input  logic [7:0]          probe_byte,
    input  boot_pkg::link_req_t core_req,
    input  boot_pkg::link_rsp_t link_rsp,
    input  logic                core_busy,
    output boot_pkg::link_req_t link_req,
    output boot_pkg::link_rsp_t core_rsp,
    output boot_pkg::prold_t    prold,
    output logic                run,
    output logic                context_init,
    output logic [31:0]         cycle_count,
    output logic [3:0]          led_stat
);

    boot_pkg::boot_state_e state;
    logic [15:0] wait_cnt;
    logic        probe_pend;
    logic        load_act;
    logic        init_act;

    logic                        prold_mode;
    logic                        prold_order;
    logic [boot_pkg::WORD_W-1:0] prold_pc;
    logic [boot_pkg::WORD_W-1:0] prold_data;

    assign run      = (state == boot_pkg::ST_RUN);
    assign load_act = (state == boot_pkg::ST_LD_WAIT) || (state == boot_pkg::ST_LD_WRITE);
    assign init_act = (state == boot_pkg::ST_INIT_CLR) || (state == boot_pkg::ST_INIT_WAIT) ||
                      (state == boot_pkg::ST_INIT_PROBE);

    assign prold = '{mode: prold_mode, order: prold_order, pc: prold_pc, data: prold_data};

    // link ownership: core in run, controller during load and probe
    always_comb begin
        link_req = '0;
        if (run) begin
            link_req = core_req;
        end else if (load_act) begin
            link_req.order = 1'b1;
            link_req.size  = boot_pkg::SZ_4;
            link_req.write = 1'b0;
        end else if (state == boot_pkg::ST_INIT_PROBE) begin
            link_req.order = probe_pend;
            link_req.size  = boot_pkg::SZ_1;
            link_req.write = 1'b1;
            link_req.wdata = {{(boot_pkg::WORD_W-8){1'b0}}, probe_byte};
        end
    end

    // core sees no handshake pulses outside run
    always_comb begin
        core_rsp          = link_rsp;
        core_rsp.accepted = link_rsp.accepted & run;
        core_rsp.done     = link_rsp.done & run;
    end

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            state        <= boot_pkg::ST_NONE;
            cycle_count  <= '0;
            wait_cnt     <= '0;
            probe_pend   <= 1'b0;
            context_init <= 1'b0;
            prold_mode   <= 1'b0;
            prold_order  <= 1'b0;
            prold_pc     <= '0;
        end else if (usr_rst) begin
            // pc kept so the loaded program survives
            state        <= boot_pkg::ST_INIT_CLR;
            cycle_count  <= '0;
            probe_pend   <= 1'b0;
            context_init <= 1'b0;
            prold_mode   <= 1'b0;
            prold_order  <= 1'b0;
        end else if (usr_load) begin
            state        <= boot_pkg::ST_LD_WAIT;
            cycle_count  <= '0;
            probe_pend   <= 1'b0;
            context_init <= 1'b0;
            prold_mode   <= 1'b1;
            prold_order  <= 1'b0;
            prold_pc     <= '0;
        end else begin
            prold_order  <= 1'b0;
            context_init <= 1'b0;
            case (state)
                boot_pkg::ST_LD_WAIT: begin
                    if (link_rsp.done) begin
                        prold_order <= 1'b1;
                        state       <= boot_pkg::ST_LD_WRITE;
                    end
                end
                boot_pkg::ST_LD_WRITE: begin
                    prold_pc <= prold_pc + 32'd4;
                    state    <= boot_pkg::ST_LD_WAIT;
                end
                boot_pkg::ST_INIT_CLR: begin
                    wait_cnt <= '0;
                    state    <= boot_pkg::ST_INIT_WAIT;
                end
                boot_pkg::ST_INIT_WAIT: begin
                    // init_wait+1 cycles in this state
                    if (wait_cnt == init_wait) begin
                        probe_pend <= 1'b1;
                        state      <= boot_pkg::ST_INIT_PROBE;
                    end else begin
                        wait_cnt <= wait_cnt + 16'd1;
                    end
                end
                boot_pkg::ST_INIT_PROBE: begin
                    if (link_rsp.accepted) begin
                        probe_pend <= 1'b0;
                    end
                    if (link_rsp.done) begin
                        context_init <= 1'b1;
                        state        <= boot_pkg::ST_RUN;
                    end
                end
                boot_pkg::ST_RUN: begin
                    cycle_count <= cycle_count + 32'd1;
                end
                boot_pkg::ST_NONE: begin
                    state <= boot_pkg::ST_NONE;
                end
                default: begin
                    state <= boot_pkg::ST_NONE;
                end
            endcase
        end
    end

    // captured word for the load record
    always_ff @(posedge clk) begin
        if ((state == boot_pkg::ST_LD_WAIT) && link_rsp.done) begin
            prold_data <= link_rsp.rdata;
        end
    end

    // status leds: load, init, run, core busy
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            led_stat <= '0;
        end else begin
            led_stat <= {load_act, init_act, run, core_busy};
        end
    end

endmodule

//--- rtl/boot_cfg.sv
`timescale 1ns/100ps

module boot_cfg (
    input  logic        clk,
    input  logic        native_rstn,
    input  logic        cfg_we,
    input  logic        cfg_addr,
    input  logic [15:0] cfg_wdata,
    output logic [15:0] init_wait,
    output logic [7:0]  probe_byte
);

    // address 0 holds the init wait length
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            init_wait <= 16'd255;
        end else if (cfg_we && (cfg_addr == 1'b0)) begin
            init_wait <= cfg_wdata;
        end
    end

    // address 1 holds the probe byte, low byte of the write data only
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            probe_byte <= 8'haa;
        end else if (cfg_we && (cfg_addr == 1'b1)) begin
            probe_byte <= cfg_wdata[7:0];
        end
    end

endmodule

//--- rtl/boot_pkg.sv
package boot_pkg;

    // data word width across link, memory and fetch port
    parameter int WORD_W = 32;

    // transfer size of one link word
    typedef enum logic [1:0] {
        SZ_1 = 2'd0,
        SZ_2 = 2'd1,
        SZ_4 = 2'd2
    } xfer_size_e;

    // request toward the uart link
    typedef struct packed {
        logic              order;
        xfer_size_e        size;
        logic              write;
        logic [WORD_W-1:0] wdata;
    } link_req_t;

    // response from the uart link
    typedef struct packed {
        logic              accepted;
        logic              done;
        logic [WORD_W-1:0] rdata;
    } link_rsp_t;

    // one program-load record with pc as a byte address
    typedef struct packed {
        logic              mode;
        logic              order;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] data;
    } prold_t;

    typedef enum logic [2:0] {
        ST_NONE,
        ST_LD_WAIT,
        ST_LD_WRITE,
        ST_INIT_CLR,
        ST_INIT_WAIT,
        ST_INIT_PROBE,
        ST_RUN
    } boot_state_e;

endpackage
